// File: quad_cmd_settings.svh
// shared macros for the ramp timer and the ack byte, pulled in by the package, execute stage and testbench
`ifndef QUAD_CMD_SETTINGS_SVH
`define QUAD_CMD_SETTINGS_SVH

// 1 selects the short ramp so calibration runs quickly in simulation
`define QC_FAST_SIM 1

// ramp timer widths, the ramp ends once every bit is set
`define QC_TMR_W_FAST 9    // 511 cycles
`define QC_TMR_W_SLOW 26   // about 1.3 s at 50 MHz

// every completed command answers with this byte
`define QC_ACK 8'hA5

// frame layout in received order
//   byte 0  opcode
//   byte 1  data high
//   byte 2  data low
`define QC_FRAME_BYTES 3

// inertial unit handshake is a plain level, nothing to configure here
// thrust uses only the low bits of the data word

`endif

// File: quad_cmd_pkg.sv
// types shared by the command decode and execute stages, imported by the RTL and the testbench
`include "quad_cmd_settings.svh"

package quad_cmd_pkg;

    // opcodes carried in the first byte of a frame
    typedef enum logic [7:0] {
        SET_PTCH  = 8'h02,
        SET_ROLL  = 8'h03,
        SET_YAW   = 8'h04,
        SET_THRST = 8'h05,
        CALIBRATE = 8'h06,
        EMER_LAND = 8'h07,
        MTRS_OFF  = 8'h08
    } opcode_t;

    typedef logic signed [15:0] attitude_t;  // pitch, roll and yaw setpoints
    typedef logic        [8:0]  thrust_t;    // thrust is unsigned

    // execute stage states
    typedef enum logic [1:0] {
        IDLE,
        RAMP_MOTORS,  // waiting for motors to spin up
        CAL           // inertial unit calibrating
    } cfg_state_t;

endpackage

// File: cmd_frame_assembler.sv
// decode stage packing received serial bytes into opcode plus 16-bit data frames for cmd_cfg
`timescale 1ns/1ns

module cmd_frame_assembler import quad_cmd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx_rdy,       // one strobe per received byte
    input  logic [7:0]  rx_data,
    input  logic        clr_cmd_rdy,  // execute stage has taken the frame
    output logic        cmd_rdy,
    output opcode_t     cmd,
    output logic [15:0] data
);

    logic [1:0] byte_cnt;    // position of the next byte in the frame
    logic [7:0] op_stage;    // opcode byte held until the frame completes
    logic [7:0] hi_stage;    // data high byte, same
    logic       frame_done;

    assign frame_done = rx_rdy && (byte_cnt == 2'd2);

    // byte position, wraps after the low data byte
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= 2'd0;
        end else if (rx_rdy) begin
            if (byte_cnt == 2'd2)
                byte_cnt <= 2'd0;
            else
                byte_cnt <= byte_cnt + 2'd1;
        end
    end

    // staging keeps cmd and data steady while a newer frame is still arriving
    always_ff @(posedge clk) begin
        if (rx_rdy && (byte_cnt == 2'd0))
            op_stage <= rx_data;
        if (rx_rdy && (byte_cnt == 2'd1))
            hi_stage <= rx_data;
    end

    // publish the whole frame on the third byte
    always_ff @(posedge clk) begin
        if (frame_done) begin
            cmd  <= opcode_t'(op_stage);  // unknown opcodes pass through as raw values
            data <= {hi_stage, rx_data};
        end
    end

    // frame ready flag
    // a frame completing on the same edge as the clear wins, it is the newer one
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            cmd_rdy <= 1'b0;
        else if (frame_done)
            cmd_rdy <= 1'b1;
        else if (clr_cmd_rdy)
            cmd_rdy <= 1'b0;
    end

endmodule

// File: setpoint_reg.sv
// holding register for one flight setpoint, instantiated per axis and for thrust in cmd_cfg
`timescale 1ns/1ns

module setpoint_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,      // capture load_val
    input  logic     zero,      // emergency clear, beats load
    input  payload_t load_val,
    output payload_t q
);

    // setpoints start at zero so nothing moves before the first command
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else if (zero)
            q <= '0;
        else if (load)
            q <= load_val;
    end

endmodule

// File: cmd_cfg.sv
// execute stage decoding command frames into setpoints, motor control and calibration sequencing
`timescale 1ns/1ns
`include "quad_cmd_settings.svh"

module cmd_cfg import quad_cmd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_rdy,       // frame waiting from the assembler
    input  opcode_t     cmd,
    input  logic [15:0] data,
    input  logic        cal_done,      // level from the inertial unit
    output logic        clr_cmd_rdy,   // one cycle, frame consumed
    output logic [7:0]  resp,
    output logic        send_resp,
    output attitude_t   d_ptch,
    output attitude_t   d_roll,
    output attitude_t   d_yaw,
    output thrust_t     thrst,
    output logic        strt_cal,      // kicks off inertial calibration
    output logic        inertial_cal,  // high for the whole calibration sequence
    output logic        motors_off     // to the ESCs
);

    // ramp length follows the simulation speed switch
    localparam int TMR_W = (`QC_FAST_SIM != 0) ? `QC_TMR_W_FAST : `QC_TMR_W_SLOW;

    cfg_state_t state;
    cfg_state_t next_state;

    logic             wr_ptch;
    logic             wr_roll;
    logic             wr_yaw;
    logic             wr_thrst;
    logic             zero_all;    // emergency land or unknown opcode
    logic             set_mtrs_off;
    logic             clr_tmr;
    logic [TMR_W-1:0] ramp_tmr;
    logic             tmr_full;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    // decode and sequencing
    always_comb begin
        next_state   = state;
        clr_cmd_rdy  = 1'b0;
        send_resp    = 1'b0;
        resp         = 8'h00;
        strt_cal     = 1'b0;
        inertial_cal = 1'b0;   // low in IDLE
        clr_tmr      = 1'b0;
        wr_ptch      = 1'b0;
        wr_roll      = 1'b0;
        wr_yaw       = 1'b0;
        wr_thrst     = 1'b0;
        zero_all     = 1'b0;
        set_mtrs_off = 1'b0;
        case (state)
            RAMP_MOTORS: begin
                inertial_cal = 1'b1;
                if (tmr_full) begin
                    strt_cal   = 1'b1;
                    next_state = CAL;
                end
            end
            CAL: begin
                inertial_cal = 1'b1;
                if (cal_done) begin       // calibration acknowledged only now
                    resp       = `QC_ACK;
                    send_resp  = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                // commands arriving during calibration simply wait here
                if (cmd_rdy) begin
                    clr_cmd_rdy = 1'b1;
                    if (cmd == CALIBRATE) begin
                        clr_tmr    = 1'b1;
                        next_state = RAMP_MOTORS;
                    end else begin
                        resp      = `QC_ACK;
                        send_resp = 1'b1;
                    end
                    case (cmd)
                        SET_PTCH:  wr_ptch      = 1'b1;
                        SET_ROLL:  wr_roll      = 1'b1;
                        SET_YAW:   wr_yaw       = 1'b1;
                        SET_THRST: wr_thrst     = 1'b1;
                        MTRS_OFF:  set_mtrs_off = 1'b1;
                        CALIBRATE: ;
                        default:   zero_all     = 1'b1;  // EMER_LAND and anything unknown
                    endcase
                end
            end
        endcase
    end

    // motor spin-up timer, counts only while ramping
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            ramp_tmr <= '0;
        else if (clr_tmr)
            ramp_tmr <= '0;
        else if (state == RAMP_MOTORS)
            ramp_tmr <= ramp_tmr + 1'b1;
    end

    assign tmr_full = &ramp_tmr;

    // motors stay off until calibration, MTRS_OFF beats the clear
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            motors_off <= 1'b1;
        else if (set_mtrs_off)
            motors_off <= 1'b1;
        else if (inertial_cal)
            motors_off <= 1'b0;
    end

    setpoint_reg #(.payload_t(attitude_t)) ptch_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (wr_ptch),
        .zero     (zero_all),
        .load_val (attitude_t'(data)),
        .q        (d_ptch)
    );

    setpoint_reg #(.payload_t(attitude_t)) roll_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (wr_roll),
        .zero     (zero_all),
        .load_val (attitude_t'(data)),
        .q        (d_roll)
    );

    setpoint_reg #(.payload_t(attitude_t)) yaw_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (wr_yaw),
        .zero     (zero_all),
        .load_val (attitude_t'(data)),
        .q        (d_yaw)
    );

    // thrust keeps only the low 9 bits
    setpoint_reg #(.payload_t(thrust_t)) thrst_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (wr_thrst),
        .zero     (zero_all),
        .load_val (data[8:0]),
        .q        (thrst)
    );

endmodule

// File: quad_cmd_top.sv
// top level of the command subsystem joining the frame decoder to the execute stage
`timescale 1ns/1ns

module quad_cmd_top import quad_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_rdy,      // byte strobe from the serial receiver
    input  logic [7:0] rx_data,
    input  logic       cal_done,    // from the inertial unit
    output logic [7:0] resp,
    output logic       send_resp,
    output attitude_t  d_ptch,
    output attitude_t  d_roll,
    output attitude_t  d_yaw,
    output thrust_t    thrst,
    output logic       strt_cal,
    output logic       inertial_cal,
    output logic       motors_off
);

    logic        cmd_rdy;
    logic        clr_cmd_rdy;  // execute stage back to the assembler
    opcode_t     cmd;
    logic [15:0] data;

    cmd_frame_assembler cmd_frame_assembler_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_rdy      (rx_rdy),
        .rx_data     (rx_data),
        .clr_cmd_rdy (clr_cmd_rdy),
        .cmd_rdy     (cmd_rdy),
        .cmd         (cmd),
        .data        (data)
    );

    cmd_cfg cmd_cfg_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_rdy      (cmd_rdy),
        .cmd          (cmd),
        .data         (data),
        .cal_done     (cal_done),
        .clr_cmd_rdy  (clr_cmd_rdy),
        .resp         (resp),
        .send_resp    (send_resp),
        .d_ptch       (d_ptch),
        .d_roll       (d_roll),
        .d_yaw        (d_yaw),
        .thrst        (thrst),
        .strt_cal     (strt_cal),
        .inertial_cal (inertial_cal),
        .motors_off   (motors_off)
    );

endmodule

// File: quad_cmd_chk.sv
// assertions on the execute stage, attached to cmd_cfg by the bind at the end of this file
`timescale 1ns/1ns
`include "quad_cmd_settings.svh"

module quad_cmd_chk import quad_cmd_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] resp,
    input logic       send_resp,
    input logic       strt_cal,
    input logic       inertial_cal,
    input logic       motors_off,
    input cfg_state_t state
);

    int fail_cnt = 0;  // summed into the testbench result

    // every response strobe carries the ack byte
    ack_byte: assert property (@(posedge clk) disable iff (!rst_n)
        send_resp |-> resp == `QC_ACK)
        else begin
            $error("send_resp high with resp %h", resp);
            fail_cnt++;
        end

    strt_cal_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        strt_cal |=> !strt_cal)
        else begin
            $error("strt_cal held longer than one cycle");
            fail_cnt++;
        end

    // calibration start only at the end of the ramp
    strt_cal_in_ramp: assert property (@(posedge clk) disable iff (!rst_n)
        strt_cal |-> inertial_cal && state == RAMP_MOTORS)
        else begin
            $error("strt_cal outside the motor ramp");
            fail_cnt++;
        end

    motors_off_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> motors_off)
        else begin
            $error("motors_off low right after reset release");
            fail_cnt++;
        end

endmodule

bind cmd_cfg quad_cmd_chk cfg_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp         (resp),
    .send_resp    (send_resp),
    .strt_cal     (strt_cal),
    .inertial_cal (inertial_cal),
    .motors_off   (motors_off),
    .state        (state)
);

// File: tb_quad_cmd.sv
// directed testbench for the quadcopter command subsystem, top module of the simulation
`timescale 1ns/1ns
`include "quad_cmd_settings.svh"

module tb_quad_cmd import quad_cmd_pkg::*; ();

    localparam int TMR_W       = (`QC_FAST_SIM != 0) ? `QC_TMR_W_FAST : `QC_TMR_W_SLOW;
    localparam int RAMP_CYCLES = 1 << TMR_W;
    localparam int RESP_LIMIT  = 16;
    // twice the two ramps plus room for the frame traffic
    localparam int TIMEOUT_CYCLES = 4 * RAMP_CYCLES + 2000;

    logic       clk;
    logic       rst_n;
    logic       rx_rdy;
    logic [7:0] rx_data;
    logic       cal_done;
    logic [7:0] resp;
    logic       send_resp;
    attitude_t  d_ptch;
    attitude_t  d_roll;
    attitude_t  d_yaw;
    thrust_t    thrst;
    logic       strt_cal;
    logic       inertial_cal;
    logic       motors_off;

    int          err_cnt;
    int          asrt_cnt;
    int          cycle_cnt;
    logic [31:0] rng;
    attitude_t   exp_ptch;   // reference model of the DUT state
    attitude_t   exp_roll;
    attitude_t   exp_yaw;
    thrust_t     exp_thrst;
    logic        exp_motors_off;

    quad_cmd_top quad_cmd_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // opcode, data high, data low, back to back
    task automatic send_frame(input logic [7:0] op, input logic [15:0] d);
        logic [7:0] frame [`QC_FRAME_BYTES];
        frame = '{op, d[15:8], d[7:0]};
        for (int i = 0; i < `QC_FRAME_BYTES; i++) begin
            @(posedge clk);
            rx_rdy  <= 1'b1;
            rx_data <= frame[i];
        end
        @(posedge clk);
        rx_rdy <= 1'b0;
    endtask

    task automatic wait_resp(input string name, output int latency);
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!send_resp && latency < RESP_LIMIT);
        if (!send_resp) begin
            $display("%s: no response within %0d cycles", name, RESP_LIMIT);
            err_cnt++;
        end else begin
            check({name, " resp"}, `QC_ACK, resp);
        end
    endtask

    task automatic apply_model(input logic [7:0] op, input logic [15:0] d);
        case (op)
            SET_PTCH:  exp_ptch = d;
            SET_ROLL:  exp_roll = d;
            SET_YAW:   exp_yaw = d;
            SET_THRST: exp_thrst = d[8:0];  // low 9 bits only
            MTRS_OFF:  exp_motors_off = 1'b1;
            CALIBRATE: exp_motors_off = 1'b0;
            default: begin
                exp_ptch  = '0;
                exp_roll  = '0;
                exp_yaw   = '0;
                exp_thrst = '0;
            end
        endcase
    endtask

    task automatic check_all(input string name);
        check({name, " d_ptch"}, exp_ptch, d_ptch);
        check({name, " d_roll"}, exp_roll, d_roll);
        check({name, " d_yaw"}, exp_yaw, d_yaw);
        check({name, " thrst"}, exp_thrst, thrst);
        check({name, " motors_off"}, exp_motors_off, motors_off);
    endtask

    task automatic run_simple(input string name, input logic [7:0] op, input logic [15:0] d);
        int lat;
        send_frame(op, d);
        wait_resp(name, lat);
        check({name, " latency"}, 1, lat);
        apply_model(op, d);
        @(negedge clk);
        check({name, " single pulse"}, 0, send_resp);
        check_all(name);
    endtask

    task automatic load_all(input string name);
        opcode_t ops [4];
        ops = '{SET_PTCH, SET_ROLL, SET_YAW, SET_THRST};
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            run_simple({name, " ", ops[i].name()}, ops[i], rng[15:0]);
        end
    endtask

    task automatic wait_strt_cal(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check({name, " no early resp"}, 0, send_resp);
            check({name, " d_ptch held"}, exp_ptch, d_ptch);
        end while (!strt_cal && n < RAMP_CYCLES + 16);
        if (!strt_cal) begin
            $display("%s: strt_cal never pulsed during the motor ramp", name);
            err_cnt++;
        end
        check({name, " inertial_cal"}, 1, inertial_cal);
        check({name, " motors_off"}, 0, motors_off);
        @(negedge clk);
        check({name, " strt_cal pulse"}, 0, strt_cal);
    endtask

    task automatic end_cal(input string name);
        int lat;
        repeat (6) @(posedge clk);  // inertial unit busy for a while
        cal_done <= 1'b1;
        wait_resp({name, " cal ack"}, lat);
        check({name, " cal ack latency"}, 1, lat);
        @(posedge clk);
        cal_done <= 1'b0;
    endtask

    task automatic verify_reset();
        @(negedge clk);
        check_all("reset");
        check("reset inertial_cal", 0, inertial_cal);
        check("reset strt_cal", 0, strt_cal);
        check("reset send_resp", 0, send_resp);
    endtask

    task automatic calibrate_sequence();
        send_frame(CALIBRATE, 16'h0000);
        apply_model(CALIBRATE, 16'h0000);
        wait_strt_cal("calibrate");
        end_cal("calibrate");
        @(negedge clk);
        check("calibrate single ack", 0, send_resp);
        check("calibrate inertial_cal low", 0, inertial_cal);
    endtask

    // a SET_PTCH arriving mid ramp must wait for the calibration ack
    task automatic queued_during_ramp();
        int          lat;
        logic [15:0] val;
        send_frame(CALIBRATE, 16'h0000);
        apply_model(CALIBRATE, 16'h0000);
        repeat (3) @(posedge clk);
        rng = xorshift32(rng);
        val = rng[15:0];
        send_frame(SET_PTCH, val);
        wait_strt_cal("queued");
        end_cal("queued");
        wait_resp("queued SET_PTCH", lat);
        check("queued SET_PTCH latency", 1, lat);
        check("queued d_ptch before write", exp_ptch, d_ptch);
        apply_model(SET_PTCH, val);
        @(negedge clk);
        check("queued single pulse", 0, send_resp);
        check_all("queued");
    endtask

    initial begin
        rst_n          = 1'b0;
        rx_rdy         = 1'b0;
        rx_data        = 8'h00;
        cal_done       = 1'b0;
        err_cnt        = 0;
        rng            = 32'd4;
        exp_ptch       = '0;
        exp_roll       = '0;
        exp_yaw        = '0;
        exp_thrst      = '0;
        exp_motors_off = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        verify_reset();
        load_all("setpoint");
        load_all("reload");
        rng = xorshift32(rng);
        run_simple("emergency land", EMER_LAND, rng[15:0]);
        load_all("reload");
        rng = xorshift32(rng);
        run_simple("unknown opcode", 8'h1F, rng[15:0]);
        calibrate_sequence();
        run_simple("motors off", MTRS_OFF, 16'h0000);
        queued_during_ramp();
        repeat (2) @(posedge clk);
        asrt_cnt = quad_cmd_top_inst.cmd_cfg_inst.cfg_chk.fail_cnt;
        $display("run complete: %0d check errors, %0d assertion failures", err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: DUT still busy after %0d cycles", cycle_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
quad_cmd_pkg.sv
cmd_frame_assembler.sv
setpoint_reg.sv
cmd_cfg.sv
quad_cmd_top.sv
quad_cmd_chk.sv
tb_quad_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the command subsystem testbench with Verilator, run it and grade the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_quad_cmd \
    -f project.f \
    -o sim_quad_cmd

./obj_dir/sim_quad_cmd +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result line, see sim.log"
    exit 1
fi
echo "simulation passed"
